//--- hw/z80_defs.svh
`ifndef Z80_DEFS_SVH
`define Z80_DEFS_SVH

// Longest opcode assembled by the predecoder, in bytes.
// Sets both the decoder lane count and the window depth.
`define Z80_MAX_INSN_LEN 2

// Width of an instruction group code.
`define Z80_GROUP_WIDTH 8

// Prefix bytes that always need a second opcode byte.
`define Z80_PREFIX_CB 8'hCB
`define Z80_PREFIX_DD 8'hDD
`define Z80_PREFIX_ED 8'hED
`define Z80_PREFIX_FD 8'hFD

`endif

//--- hw/z80GroupPkg.sv
`include "z80_defs.svh"

package z80GroupPkg;

    // Group codes handed to the sequencer.
    // Values are fixed so the core's microsequence table can index them.
    typedef enum logic [`Z80_GROUP_WIDTH-1:0] {
        NeedMoreBytes = 0,  // Opcode not complete yet.
        IllegalInstr  = 1,
        LdDdImmed     = 2,  // LD dd,nn.
        LdBcdeA       = 3,  // LD (BC),A and LD (DE),A.
        LdRegImmed    = 4,  // LD r,n.
        LdHlImmed     = 5,  // LD (HL),n.
        LdRegReg      = 6,  // LD r,r'.
        LdExtaddrA    = 7,  // LD (nn),A.
        LdAExtaddr    = 8,  // LD A,(nn).
        LdHlReg       = 9,  // LD (HL),r.
        LdDdExtaddr   = 10, // LD dd,(nn).
        LdExtaddrDd   = 11, // LD (nn),dd.
        LdRegIxiy     = 12, // LD r,(IX/IY+d).
        LdIxiyReg     = 13, // LD (IX/IY+d),r.
        LdIxiyImmed   = 14  // LD (IX/IY+d),n.
    } insnGroup;

endpackage

//--- hw/z80FetchPkg.sv
`include "z80_defs.svh"

package z80FetchPkg;

    typedef logic [7:0] opByte;

    // Element 0 holds the first byte received, so an ED 4B
    // sequence reads as 16'h4BED.
    typedef opByte [`Z80_MAX_INSN_LEN-1:0] opWindow;

    // Byte count, 0 up to the maximum opcode length.
    typedef logic [$clog2(`Z80_MAX_INSN_LEN+1)-1:0] insnLen;

endpackage

//--- hw/opcodeWindow.sv
`timescale 1ns/1ps

`include "z80_defs.svh"

module opcodeWindow
    import z80FetchPkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    byteValid,
    input  opByte   byteIn,
    input  logic    consume,
    output opWindow window,
    output insnLen  fill
);

    localparam int SlotW = (`Z80_MAX_INSN_LEN > 1) ? $clog2(`Z80_MAX_INSN_LEN) : 1;

    always_ff @(posedge clk) begin
        if (rst) begin
            fill <= '0;
        end else if (consume) begin
            fill <= byteValid ? insnLen'(1) : insnLen'(0); // Fresh window.
        end else if (byteValid) begin
            fill <= fill + insnLen'(1);
        end
    end

    // Payload bytes.
    always_ff @(posedge clk) begin
        if (consume) begin
            window <= '0;
            if (byteValid) begin
                window[0] <= byteIn;  // Byte starts the next opcode.
            end
        end else if (byteValid) begin
            window[fill[SlotW-1:0]] <= byteIn;
        end
    end

endmodule

//--- hw/instrDecoder.sv
`timescale 1ns/1ps

`include "z80_defs.svh"

module instrDecoder
    import z80GroupPkg::*;
    import z80FetchPkg::*;
#(
    parameter int laneLen = 1
) (
    input  opWindow  window,
    output insnGroup group
);

    logic [15:0] pair;

    assign pair = {window[1], window[0]};

    always_comb begin
        group = IllegalInstr;
        if (laneLen == 1) begin
            case (window[0])
                8'h01, 8'h11, 8'h21, 8'h31:
                    group = LdDdImmed;
                8'h02, 8'h12:
                    group = LdBcdeA;
                8'h06, 8'h0E, 8'h16, 8'h1E, 8'h26, 8'h2E, 8'h3E:
                    group = LdRegImmed;
                8'h36:
                    group = LdHlImmed;
                8'h40, 8'h41, 8'h42, 8'h43, 8'h44, 8'h45, 8'h47,
                8'h48, 8'h49, 8'h4A, 8'h4B, 8'h4C, 8'h4D, 8'h4F,
                8'h50, 8'h51, 8'h52, 8'h53, 8'h54, 8'h55, 8'h57,
                8'h58, 8'h59, 8'h5A, 8'h5B, 8'h5C, 8'h5D, 8'h5F,
                8'h60, 8'h61, 8'h62, 8'h63, 8'h64, 8'h65, 8'h67,
                8'h68, 8'h69, 8'h6A, 8'h6B, 8'h6C, 8'h6D, 8'h6F,
                8'h78, 8'h79, 8'h7A, 8'h7B, 8'h7C, 8'h7D, 8'h7F:
                    group = LdRegReg;
                8'h32:
                    group = LdExtaddrA;
                8'h3A:
                    group = LdAExtaddr;
                8'h70, 8'h71, 8'h72, 8'h73, 8'h74, 8'h75, 8'h77:
                    group = LdHlReg;
                `Z80_PREFIX_CB, `Z80_PREFIX_DD, `Z80_PREFIX_ED, `Z80_PREFIX_FD:
                    group = NeedMoreBytes;  // Wait for the second byte.
                default:
                    group = IllegalInstr;
            endcase
        end else if (laneLen == 2) begin
            // Prefix sits in the low byte.
            case (pair)
                16'h4BED, 16'h5BED, 16'h6BED, 16'h7BED:
                    group = LdDdExtaddr;
                16'h43ED, 16'h53ED, 16'h63ED, 16'h73ED:
                    group = LdExtaddrDd;
                16'h46DD, 16'h4EDD, 16'h56DD, 16'h5EDD,
                16'h66DD, 16'h6EDD, 16'h7EDD,
                16'h46FD, 16'h4EFD, 16'h56FD, 16'h5EFD,
                16'h66FD, 16'h6EFD, 16'h7EFD:
                    group = LdRegIxiy;
                16'h70DD, 16'h71DD, 16'h72DD, 16'h73DD,
                16'h74DD, 16'h75DD, 16'h77DD,
                16'h70FD, 16'h71FD, 16'h72FD, 16'h73FD,
                16'h74FD, 16'h75FD, 16'h77FD:
                    group = LdIxiyReg;
                16'h36DD, 16'h36FD:
                    group = LdIxiyImmed;
                // Every other pair ends here, so nothing waits past two bytes.
                default:
                    group = IllegalInstr;
            endcase
        end
    end

endmodule

//--- hw/groupArbiter.sv
`timescale 1ns/1ps

`include "z80_defs.svh"

module groupArbiter
    import z80GroupPkg::*;
    import z80FetchPkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  insnLen   fill,
    input  insnGroup laneGroup [`Z80_MAX_INSN_LEN],
    output logic     consume,
    output logic     groupValid,
    output insnGroup group,
    output insnLen   length
);

    insnGroup selGroup;

    // Lane k decodes k+1 bytes.
    always_comb begin
        selGroup = NeedMoreBytes;
        for (int k = 0; k < `Z80_MAX_INSN_LEN; k++) begin
            if (fill == insnLen'(k + 1)) begin
                selGroup = laneGroup[k];
            end
        end
    end

    assign consume = (fill != '0) && (selGroup != NeedMoreBytes);

    always_ff @(posedge clk) begin
        if (rst) begin
            groupValid <= 1'b0;
            group      <= NeedMoreBytes;
            length     <= '0;
        end else begin
            groupValid <= consume;  // One pulse per opcode.
            if (consume) begin
                group  <= selGroup;
                length <= fill;
            end
        end
    end

endmodule

//--- hw/z80Predecoder.sv
`timescale 1ns/1ps

`include "z80_defs.svh"

module z80Predecoder
    import z80GroupPkg::*;
    import z80FetchPkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     byteValid,
    input  opByte    byteIn,
    output logic     groupValid,
    output insnGroup group,
    output insnLen   length
);

    opWindow  window;
    insnLen   fill;
    logic     consume;
    insnGroup laneGroup [`Z80_MAX_INSN_LEN];

    opcodeWindow uWindow (
        .clk       (clk),
        .rst       (rst),
        .byteValid (byteValid),
        .byteIn    (byteIn),
        .consume   (consume),
        .window    (window),
        .fill      (fill)
    );

    // One lane per candidate opcode length.
    for (genvar lane = 0; lane < `Z80_MAX_INSN_LEN; lane++) begin : gLane
        instrDecoder #(.laneLen(lane + 1)) uDecoder (
            .window (window),
            .group  (laneGroup[lane])
        );
    end

    groupArbiter uArbiter (
        .clk        (clk),
        .rst        (rst),
        .fill       (fill),
        .laneGroup  (laneGroup),
        .consume    (consume),
        .groupValid (groupValid),
        .group      (group),
        .length     (length)
    );

endmodule

//--- tb/z80PredecoderTb.sv
`timescale 1ns/1ps

module z80PredecoderTb
    import z80GroupPkg::*;
    import z80FetchPkg::*;
;

    localparam int MaxRows  = 64;
    localparam int RowWords = 5;   // Count, byte 0, byte 1, group, length.
    localparam int ResetCycles = 8;
    localparam int BurstRows = 8;  // Leading rows streamed with no gaps.

    logic     clk;
    logic     rst;
    logic     byteValid;
    opByte    byteIn;
    logic     groupValid;
    insnGroup group;
    insnLen   length;

    logic [7:0] patMem [0:MaxRows*RowWords-1];
    int rowCount = 0;
    int cycleCount = 0;
    int seed = 32'h9060_c001;

    // Expected results, oldest first.
    int groupQ [$];
    int lenQ [$];
    int dueQ [$];
    int rowQ [$];

    z80Predecoder UUT (
        .clk        (clk),
        .rst        (rst),
        .byteValid  (byteValid),
        .byteIn     (byteIn),
        .groupValid (groupValid),
        .group      (group),
        .length     (length)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    task automatic checkValue(input string testName, input int expected, input int actual);
        if (expected != actual) begin
            $display("Error %s expected %0d actual %0d", testName, expected, actual);
            $display(">>> FAIL");
            $fatal(1, "Mismatch in %s", testName);
        end
    endtask

    task automatic sendByte(input opByte b);
        @(posedge clk);
        byteValid <= 1'b1;
        byteIn    <= b;
    endtask

    task automatic idleCycles(input int n);
        repeat (n) begin
            @(posedge clk);
            byteValid <= 1'b0;
        end
    endtask

    // Monitor. Outputs are stable at the falling edge.
    always @(negedge clk) begin
        cycleCount = cycleCount + 1;
        if (dueQ.size() != 0 && dueQ[0] == cycleCount) begin
            checkValue($sformatf("row %0d groupValid", rowQ[0]), 1, int'(groupValid));
            checkValue($sformatf("row %0d group", rowQ[0]), groupQ[0], int'(group));
            checkValue($sformatf("row %0d length", rowQ[0]), lenQ[0], int'(length));
            void'(groupQ.pop_front());
            void'(lenQ.pop_front());
            void'(dueQ.pop_front());
            void'(rowQ.pop_front());
        end else if (groupValid) begin
            $display("Unexpected result: groupValid pulsed at cycle %0d with no opcode due",
                     cycleCount);
            $display(">>> FAIL");
            $fatal(1, "Stray groupValid pulse");
        end
    end

    // Watchdog sized from the number of rows once reset ends.
    initial begin
        @(negedge rst);
        repeat (rowCount * 6) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles",
                 ResetCycles + rowCount * 6);
        $display(">>> FAIL");
        $fatal(1, "Watchdog expired");
    end

    initial begin
        int count;
        int gap;
        int gapInside;
        int base;
        rst       = 1'b1;
        byteValid = 1'b0;
        byteIn    = '0;
        for (int i = 0; i < MaxRows * RowWords; i++) begin
            patMem[i] = 8'h00;
        end
        $readmemh("tb/predecode_patterns.txt", patMem);
        while (rowCount < MaxRows && patMem[rowCount * RowWords] != 8'h00) begin
            rowCount++;
        end
        if (rowCount == 0) begin
            $display("Pattern file holds no rows");
            $display(">>> FAIL");
            $fatal(1, "Empty pattern file");
        end

        repeat (ResetCycles) @(posedge clk);
        rst <= 1'b0;

        for (int r = 0; r < rowCount; r++) begin
            base      = r * RowWords;
            count     = int'(patMem[base]);
            gap       = (r < BurstRows) ? 0 : ($random(seed) & 3);
            gapInside = (count == 2) ? ($random(seed) & 1) : 0;
            if (gapInside == 0) begin
                idleCycles(gap);
            end
            sendByte(patMem[base + 1]);
            if (count == 2) begin
                if (gapInside != 0) begin
                    idleCycles(gap); // Stall between prefix and second byte.
                end
                sendByte(patMem[base + 2]);
            end
            // Result due two cycles after the strobe of this last byte.
            groupQ.push_back(int'(patMem[base + 3]));
            lenQ.push_back(int'(patMem[base + 4]));
            dueQ.push_back(cycleCount + 3);
            rowQ.push_back(r);
        end

        idleCycles(1);
        while (dueQ.size() != 0) @(posedge clk);
        idleCycles(4); // Idle stream must stay quiet.

        $display(">>> PASS");
        $finish;
    end

endmodule

//--- tb/predecode_patterns.txt
// Columns: byte count, first byte, second byte, expected group, expected length.
// A count of 00 ends the table.
01 40 00 06 01
02 ED 4B 0A 02
01 3A 00 08 01
02 DD 46 0C 02
01 00 00 01 01
02 FD 77 0D 02
01 77 00 09 01
02 ED 00 01 02
01 01 00 02 01
01 31 00 02 01
01 02 00 03 01
01 12 00 03 01
02 ED 7B 0A 02
01 06 00 04 01
01 3E 00 04 01
02 ED 43 0B 02
01 36 00 05 01
01 7F 00 06 01
02 ED 53 0B 02
01 5A 00 06 01
01 32 00 07 01
02 FD 7E 0C 02
01 70 00 09 01
01 76 00 01 01
02 DD 70 0D 02
01 46 00 01 01
02 DD 36 0E 02
01 C3 00 01 01
02 FD 36 0E 02
01 FF 00 01 01
02 DD 21 01 02
02 CB 00 01 02
02 FD FD 01 02
02 CB 47 01 02
01 4F 00 06 01
01 6B 00 06 01
01 11 00 02 01
01 2E 00 04 01

//--- z80Predecoder.f
+incdir+hw
hw/z80GroupPkg.sv
hw/z80FetchPkg.sv
hw/opcodeWindow.sv
hw/instrDecoder.sv
hw/groupArbiter.sv
hw/z80Predecoder.sv
tb/z80PredecoderTb.sv

//--- Makefile
# Verilator build and run of the Z80 opcode predecoder testbench.

BIN  := obj_dir/Vz80PredecoderTb
SRCS := $(filter-out +%,$(shell cat z80Predecoder.f)) hw/z80_defs.svh

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes.
$(BIN): z80Predecoder.f $(SRCS)
	verilator --binary --timing -j 0 -f z80Predecoder.f --top-module z80PredecoderTb

# Pass only when the pass line appears in the output.
run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF '>>> PASS'

clean:
	rm -rf obj_dir
